//--- all.f
src/exec_pkg.sv
src/issue_if.sv
src/issue_queue.sv
src/alu_lane.sv
src/reorder_buffer.sv
src/ooo_exec_core.sv
bench/ooo_exec_core_tb.sv

//--- bench/ooo_exec_core_tb.sv
// testbench for the out-of-order execution back end with an in-order result scoreboard
`timescale 1ns/1ps

module ooo_exec_core_tb;
	import exec_pkg::*;

	localparam int lanes = 2;
	localparam int rob_depth = 8;
	// cycle limits for the wait loops
	localparam int slot_limit = 2000;
	localparam int drain_limit = 5000;

	logic              clock;
	logic              rst;
	logic              in_valid;
	alu_op_t           in_op;
	logic [xlen-1:0]   in_a;
	logic [xlen-1:0]   in_b;
	logic [areg_w-1:0] in_dest;
	logic              full;
	logic              commit_valid;
	logic [areg_w-1:0] commit_dest;
	logic [xlen-1:0]   commit_data;

	// expected commits in age order
	logic [areg_w-1:0] exp_dest [$];
	logic [xlen-1:0]   exp_data [$];

	string       test_name;
	int          errors;
	int          accepted;
	int          commits;
	int          test_acc;
	int          test_com;
	logic        full_seen;
	// set once a wait gives up so later waits are skipped
	logic        timed_out;
	logic [31:0] lcg_state;

	ooo_exec_core #(.LANES(lanes), .ROB_DEPTH(rob_depth)) dut0 (
		.clock        (clock),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_a         (in_a),
		.in_b         (in_b),
		.in_dest      (in_dest),
		.full         (full),
		.commit_valid (commit_valid),
		.commit_dest  (commit_dest),
		.commit_data  (commit_data)
	);

	// 100 ns period
	always #50 clock = ~clock;

	//////////////////////////////////////////////////
	// random source and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic alu_op_t draw_op(input int n_ops);
		logic [31:0] r;
		r = lcg_next();
		return alu_op_t'(4'(r % 32'(n_ops)));
	endfunction

	// expected result straight from the opcode rules
	function automatic logic [xlen-1:0] golden_alu(input alu_op_t op,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [63:0]     prod;
		logic [4:0]      sh;
		logic [xlen-1:0] fill;
		sh   = b[4:0];
		prod = {32'd0, a} * {32'd0, b};
		// sign bits shifted in from the top
		fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			// with differing signs the negative one is smaller
			op_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			op_sltu: return {31'd0, a < b};
			op_sll:  return a << sh;
			op_srl:  return a >> sh;
			op_sra:  return (a >> sh) | fill;
			op_mul:  return prod[31:0];
			default: return 32'd0;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// run control and stimulus
	//////////////////////////////////////////////////

	task automatic finish_run();
		$display("errors: %0d  accepted: %0d  committed: %0d", errors, accepted, commits);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	task automatic report_timeout(input string msg);
		$display("%s: %s", test_name, msg);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_acc  = accepted;
		test_com  = commits;
	endtask

	// waits for a slot the reorder buffer is sure to have at the next edge
	task automatic send_op(input alu_op_t op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b, input logic [areg_w-1:0] dest);
		int waited;
		waited = 0;
		@(posedge clock);
		while (!timed_out && exp_dest.size() >= rob_depth && waited < slot_limit) begin
			in_valid <= 1'b0;
			@(posedge clock);
			waited++;
		end
		if (waited >= slot_limit) begin
			report_timeout("timed out waiting for a free reorder buffer slot");
		end
		if (timed_out) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= 1'b1;
			in_op    <= op;
			in_a     <= a;
			in_b     <= b;
			in_dest  <= dest;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			in_valid <= 1'b0;
		end
	endtask

	// drain then compare the counts of this test
	task automatic finish_test(input int n);
		int waited;
		waited = 0;
		@(posedge clock);
		in_valid <= 1'b0;
		while (!timed_out && exp_dest.size() != 0 && waited < drain_limit) begin
			@(posedge clock);
			waited++;
		end
		if (waited >= drain_limit) begin
			report_timeout("timed out waiting for outstanding instructions to commit");
		end
		if (!timed_out) begin
			if (accepted - test_acc != n) begin
				$display("Error %s: accepted expected %0d actual %0d", test_name, n,
					accepted - test_acc);
				errors++;
			end
			if (commits - test_com != n) begin
				$display("Error %s: commits expected %0d actual %0d", test_name, n,
					commits - test_com);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!rst) begin
			if (commit_valid) begin
				if (exp_dest.size() == 0) begin
					$display("%s: commit seen with nothing outstanding", test_name);
					errors++;
				end else begin
					if (commit_dest !== exp_dest[0]) begin
						$display("Error %s: dest expected %0d actual %0d", test_name,
							exp_dest[0], commit_dest);
						errors++;
					end
					if (commit_data !== exp_data[0]) begin
						$display("Error %s: data expected %08h actual %08h", test_name,
							exp_data[0], commit_data);
						errors++;
					end
					void'(exp_dest.pop_front());
					void'(exp_data.pop_front());
				end
				commits++;
			end
			// queue size now equals reorder buffer occupancy
			if (full !== (exp_dest.size() == rob_depth)) begin
				$display("Error %s: full expected %0d actual %0b", test_name,
					exp_dest.size() == rob_depth, full);
				errors++;
			end
			if (full) begin
				full_seen = 1'b1;
			end
			// taken at the coming edge
			if (in_valid && !full) begin
				exp_dest.push_back(in_dest);
				exp_data.push_back(golden_alu(in_op, in_a, in_b));
				accepted++;
			end
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		alu_op_t     op;
		clock     = 1'b0;
		rst       = 1'b1;
		in_valid  = 1'b0;
		in_op     = op_add;
		in_a      = '0;
		in_b      = '0;
		in_dest   = '0;
		errors    = 0;
		accepted  = 0;
		commits   = 0;
		full_seen = 1'b0;
		timed_out = 1'b0;
		lcg_state = 32'd65777;
		test_name = "reset";
		repeat (4) @(posedge clock);
		rst <= 1'b0;

		// reset state and a quiet stretch
		start_test("reset");
		@(negedge clock);
		if (full !== 1'b0) begin
			$display("Error %s: full expected 0 actual %b", test_name, full);
			errors++;
		end
		if (commit_valid !== 1'b0) begin
			$display("Error %s: commit_valid expected 0 actual %b", test_name, commit_valid);
			errors++;
		end
		idle_cycles(10);
		finish_test(0);

		start_test("single_cycle");
		for (int i = 0; i < 200; i++) begin
			op = draw_op(11);
			while (is_multicycle(op)) begin
				op = draw_op(11);
			end
			r = lcg_next();
			send_op(op, lcg_next(), lcg_next(), r[areg_w-1:0]);
		end
		finish_test(200);

		// later single-cycle ops overtake the multiply
		start_test("out_of_order");
		for (int i = 0; i < 4; i++) begin
			send_op(op_mul, lcg_next(), lcg_next(), areg_w'(i));
			if ((i % 2) == 1) begin
				send_op(op_mul, lcg_next(), lcg_next(), 5'd30);
			end
			send_op(op_add, lcg_next(), lcg_next(), 5'd10);
			send_op(op_sub, lcg_next(), lcg_next(), 5'd11);
			send_op(op_xor, lcg_next(), lcg_next(), 5'd12);
			send_op(op_sll, lcg_next(), lcg_next(), 5'd13);
		end
		finish_test(22);

		start_test("back_pressure");
		full_seen = 1'b0;
		for (int i = 0; i < rob_depth + 4; i++) begin
			send_op(op_mul, lcg_next(), lcg_next(), areg_w'(i));
		end
		if (!full_seen) begin
			$display("%s: full never rose during the multiply burst", test_name);
			errors++;
		end
		finish_test(rob_depth + 4);
		if (full !== 1'b0) begin
			$display("Error %s: full expected 0 actual %b", test_name, full);
			errors++;
		end

		start_test("corner_values");
		send_op(op_slt,  32'hffff_ffff, 32'd1, 5'd1);
		send_op(op_sltu, 32'hffff_ffff, 32'd1, 5'd2);
		send_op(op_slt,  32'h8000_0000, 32'h7fff_ffff, 5'd3);
		send_op(op_sltu, 32'h8000_0000, 32'h7fff_ffff, 5'd4);
		send_op(op_slt,  32'h7fff_ffff, 32'hffff_fffe, 5'd5);
		send_op(op_sra,  32'h8000_0000, 32'd31, 5'd6);
		send_op(op_sra,  32'hf000_0000, 32'd4, 5'd7);
		send_op(op_sra,  32'h8765_4321, 32'd0, 5'd8);
		send_op(op_sll,  32'h1234_5679, 32'd31, 5'd9);
		send_op(op_srl,  32'h8000_0000, 32'd31, 5'd10);
		// only b[4:0] counts so the amount is zero
		send_op(op_sll,  32'hdead_beef, 32'hffff_ffe0, 5'd11);
		send_op(op_mul,  32'hffff_ffff, 32'hffff_ffff, 5'd12);
		send_op(op_mul,  32'hffff_ffff, 32'd0, 5'd13);
		send_op(op_mul,  32'd0, 32'hffff_ffff, 5'd14);
		send_op(op_mul,  32'hffff_ffff, 32'd1, 5'd15);
		finish_test(15);

		// every opcode with gaps in in_valid
		start_test("random_mix");
		for (int i = 0; i < 300; i++) begin
			op = draw_op(11);
			r  = lcg_next();
			send_op(op, lcg_next(), lcg_next(), r[areg_w-1:0]);
			if (r[9:8] == 2'd0) begin
				idle_cycles(int'(r[11:10]) + 1);
			end
		end
		finish_test(300);

		finish_run();
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the execution back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ooo_exec_core_tb -f all.f -o ooo_exec_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/ooo_exec_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- src/alu_lane.sv
// ALU execution lane with single-cycle ops and an iterative shift-add multiplier
`timescale 1ns/1ps

module alu_lane #(
	parameter int ROB_DEPTH = 8
) (
	input  logic                          clock,
	input  logic                          rst,
	issue_if.lane                         issue,
	output logic                          done,
	output logic [$clog2(ROB_DEPTH)-1:0]  done_tag,
	output logic [exec_pkg::xlen-1:0]     done_data
);
	import exec_pkg::*;

	localparam int cnt_w = $clog2(xlen);

	typedef enum logic {
		lane_idle,
		lane_mul
	} lane_state_t;

	lane_state_t state;

	// multiplier datapath
	logic [xlen-1:0]  mcand;
	logic [xlen-1:0]  mplier;
	logic [xlen-1:0]  acc;
	logic [xlen-1:0]  acc_next;
	logic [cnt_w-1:0] mul_cnt;

	// new op accepted this cycle
	logic start;

	// single-cycle result
	function automatic logic [xlen-1:0] alu_calc(input alu_op_t op,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_slt:  return {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			op_sltu: return {{(xlen-1){1'b0}}, a < b};
			op_sll:  return a << sh;
			op_srl:  return a >> sh;
			op_sra:  return $signed(a) >>> sh;
			default: return '0;
		endcase
	endfunction

	assign start    = (state == lane_idle) && issue.valid;
	assign acc_next = acc + (mplier[0] ? mcand : '0);

	// held from the edge after a multiply issues
	assign issue.busy = (state == lane_mul);

	////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= lane_idle;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				lane_idle: begin
					if (start && is_multicycle(issue.op)) begin
						state <= lane_mul;
					end else if (start) begin
						done <= 1'b1;
					end
				end
				lane_mul: begin
					// last step, result leaves with done
					if (mul_cnt == '0) begin
						state <= lane_idle;
						done  <= 1'b1;
					end
				end
				default: state <= lane_idle;
			endcase
		end
	end

	////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (start) begin
			done_tag  <= issue.tag;
			done_data <= alu_calc(issue.op, issue.a, issue.b);
			// multiply setup, unused by other ops
			mcand     <= issue.a;
			mplier    <= issue.b;
			acc       <= '0;
			mul_cnt   <= cnt_w'(xlen - 1);
		end else if (state == lane_mul) begin
			// one partial product per cycle
			mcand     <= mcand << 1;
			mplier    <= mplier >> 1;
			acc       <= acc_next;
			mul_cnt   <= mul_cnt - 1'b1;
			done_data <= acc_next;
		end
	end

endmodule

//--- src/exec_pkg.sv
// execution back end shared definitions: data widths, ALU opcodes, latency class
package exec_pkg;

	////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////

	// operand and result width
	parameter int xlen = 32;

	// architectural destination register index
	parameter int areg_w = 5;

	////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////

	// integer ops handled by every lane
	// shifts take the amount from b[4:0]
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		// signed compare
		op_slt  = 4'd5,
		// unsigned compare
		op_sltu = 4'd6,
		op_sll  = 4'd7,
		op_srl  = 4'd8,
		// arithmetic right shift keeps the sign
		op_sra  = 4'd9,
		// low word of the product only
		op_mul  = 4'd10
	} alu_op_t;

	////////////////////////////////////////////////
	// latency class
	////////////////////////////////////////////////

	// ops that hold a lane for many cycles
	// everything else finishes in one
	function automatic logic is_multicycle(input alu_op_t op);
		return (op == op_mul);
	endfunction

endpackage

//--- src/issue_if.sv
// issue slot carrying one operation from the issue queue to a single ALU lane
`timescale 1ns/1ps

interface issue_if #(
	parameter int ROB_DEPTH = 8
);
	import exec_pkg::*;

	// one-cycle strobe, only while busy is low
	logic valid;
	alu_op_t op;

	// operand values, already read
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;

	// reorder buffer slot of this op
	logic [$clog2(ROB_DEPTH)-1:0] tag;

	// level, lane stuck in a multiply
	logic busy;

	// issue queue drives the op
	modport queue (output valid, op, a, b, tag, input busy);

	// lane takes the op and reports busy
	modport lane (input valid, op, a, b, tag, output busy);

endinterface

//--- src/issue_queue.sv
// age-ordered issue queue handing the oldest ready entries to idle ALU lanes
`timescale 1ns/1ps

module issue_queue #(
	parameter int LANES = 2,
	parameter int ROB_DEPTH = 8
) (
	input  logic                          clock,
	input  logic                          rst,
	input  logic                          in_valid,
	input  exec_pkg::alu_op_t             in_op,
	input  logic [exec_pkg::xlen-1:0]     in_a,
	input  logic [exec_pkg::xlen-1:0]     in_b,
	input  logic [$clog2(ROB_DEPTH)-1:0]  alloc_tag,
	issue_if.queue                        issue [LANES]
);
	import exec_pkg::*;

	localparam int tag_w = $clog2(ROB_DEPTH);

	// entry storage, circular in age order
	alu_op_t          q_op  [ROB_DEPTH];
	logic [xlen-1:0]  q_a   [ROB_DEPTH];
	logic [xlen-1:0]  q_b   [ROB_DEPTH];
	logic [tag_w-1:0] q_tag [ROB_DEPTH];

	// pointers with an extra wrap bit
	logic [tag_w:0]   head;
	logic [tag_w:0]   tail;
	logic [tag_w:0]   count;
	logic [tag_w-1:0] tail_idx;

	// per-lane view of the issue slots
	logic             lane_busy [LANES];
	logic             lane_go   [LANES];
	logic [tag_w-1:0] lane_idx  [LANES];

	// entries leaving this cycle
	logic [tag_w:0]   n_issue;

	assign tail_idx = tail[tag_w-1:0];
	assign count    = tail - head;

	////////////////////////////////////////////////
	// lane selection
	////////////////////////////////////////////////

	// walk the lanes in order
	// each idle lane takes the next oldest entry
	always_comb begin
		logic [tag_w:0] taken;
		taken = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_go[i]  = 1'b0;
			lane_idx[i] = head[tag_w-1:0];
			if (!lane_busy[i] && (taken < count)) begin
				lane_go[i]  = 1'b1;
				// wraps with the buffer
				lane_idx[i] = head[tag_w-1:0] + taken[tag_w-1:0];
				taken       = taken + 1'b1;
			end
		end
		n_issue = taken;
	end

	// drive each slot from its picked entry
	for (genvar g = 0; g < LANES; g++) begin : g_slot
		assign lane_busy[g]  = issue[g].busy;
		assign issue[g].valid = lane_go[g];
		assign issue[g].op    = q_op[lane_idx[g]];
		assign issue[g].a     = q_a[lane_idx[g]];
		assign issue[g].b     = q_b[lane_idx[g]];
		assign issue[g].tag   = q_tag[lane_idx[g]];
	end

	////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			// depth matches the reorder buffer, never overflows
			if (in_valid) begin
				tail <= tail + 1'b1;
			end
			head <= head + n_issue;
		end
	end

	// write the new entry at the tail
	always_ff @(posedge clock) begin
		if (in_valid) begin
			q_op[tail_idx]  <= in_op;
			q_a[tail_idx]   <= in_a;
			q_b[tail_idx]   <= in_b;
			q_tag[tail_idx] <= alloc_tag;
		end
	end

endmodule

//--- src/ooo_exec_core.sv
// out-of-order execution back end: issue queue, ALU lanes and reorder buffer
`timescale 1ns/1ps

module ooo_exec_core #(
	parameter int LANES = 2,
	parameter int ROB_DEPTH = 8
) (
	input  logic                         clock,
	input  logic                         rst,
	input  logic                         in_valid,
	input  exec_pkg::alu_op_t            in_op,
	input  logic [exec_pkg::xlen-1:0]    in_a,
	input  logic [exec_pkg::xlen-1:0]    in_b,
	input  logic [exec_pkg::areg_w-1:0]  in_dest,
	output logic                         full,
	output logic                         commit_valid,
	output logic [exec_pkg::areg_w-1:0]  commit_dest,
	output logic [exec_pkg::xlen-1:0]    commit_data
);
	import exec_pkg::*;

	// tail slot for the incoming op
	logic [$clog2(ROB_DEPTH)-1:0] alloc_tag;

	// completion bus, one slot per lane
	logic                         lane_done      [LANES];
	logic [$clog2(ROB_DEPTH)-1:0] lane_done_tag  [LANES];
	logic [xlen-1:0]              lane_done_data [LANES];

	issue_if #(.ROB_DEPTH(ROB_DEPTH)) issue_bus [LANES] ();

	////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////

	// queue only sees ops the reorder buffer takes
	issue_queue #(.LANES(LANES), .ROB_DEPTH(ROB_DEPTH)) u_queue (
		.clock     (clock),
		.rst       (rst),
		.in_valid  (in_valid && !full),
		.in_op     (in_op),
		.in_a      (in_a),
		.in_b      (in_b),
		.alloc_tag (alloc_tag),
		.issue     (issue_bus)
	);

	////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		alu_lane #(.ROB_DEPTH(ROB_DEPTH)) u_lane (
			.clock     (clock),
			.rst       (rst),
			.issue     (issue_bus[g]),
			.done      (lane_done[g]),
			.done_tag  (lane_done_tag[g]),
			.done_data (lane_done_data[g])
		);
	end

	////////////////////////////////////////////////
	// complete and commit
	////////////////////////////////////////////////

	reorder_buffer #(.LANES(LANES), .ROB_DEPTH(ROB_DEPTH)) u_rob (
		.clock        (clock),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_dest      (in_dest),
		.alloc_tag    (alloc_tag),
		.full         (full),
		.done         (lane_done),
		.done_tag     (lane_done_tag),
		.done_data    (lane_done_data),
		.commit_valid (commit_valid),
		.commit_dest  (commit_dest),
		.commit_data  (commit_data)
	);

endmodule

//--- src/reorder_buffer.sv
// reorder buffer that allocates tags, collects lane results and commits in order
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int LANES = 2,
	parameter int ROB_DEPTH = 8
) (
	input  logic                          clock,
	input  logic                          rst,
	input  logic                          in_valid,
	input  logic [exec_pkg::areg_w-1:0]   in_dest,
	output logic [$clog2(ROB_DEPTH)-1:0]  alloc_tag,
	output logic                          full,
	input  logic                          done      [LANES],
	input  logic [$clog2(ROB_DEPTH)-1:0]  done_tag  [LANES],
	input  logic [exec_pkg::xlen-1:0]     done_data [LANES],
	output logic                          commit_valid,
	output logic [exec_pkg::areg_w-1:0]   commit_dest,
	output logic [exec_pkg::xlen-1:0]     commit_data
);
	import exec_pkg::*;

	localparam int tag_w = $clog2(ROB_DEPTH);

	// head is oldest, tail is next free slot
	logic [tag_w:0]   head;
	logic [tag_w:0]   tail;
	logic [tag_w-1:0] head_idx;
	logic [tag_w-1:0] tail_idx;

	// per-entry state
	logic [areg_w-1:0]    ent_dest [ROB_DEPTH];
	logic [xlen-1:0]      ent_data [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] ent_done;

	logic empty;
	logic alloc;
	logic retire;

	assign head_idx = head[tag_w-1:0];
	assign tail_idx = tail[tag_w-1:0];

	// same slot, wrap bits differ
	assign empty = (head == tail);
	assign full  = (head[tag_w] != tail[tag_w]) && (head_idx == tail_idx);

	// input while full is dropped
	assign alloc     = in_valid && !full;
	assign alloc_tag = tail_idx;

	// oldest entry finished
	assign retire = !empty && ent_done[head_idx];

	////////////////////////////////////////////////
	// pointers and completion flags
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			head         <= '0;
			tail         <= '0;
			ent_done     <= '0;
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
			if (alloc) begin
				tail               <= tail + 1'b1;
				ent_done[tail_idx] <= 1'b0;
			end
			// tags differ across lanes
			for (int i = 0; i < LANES; i++) begin
				if (done[i]) begin
					ent_done[done_tag[i]] <= 1'b1;
				end
			end
			if (retire) begin
				head <= head + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////
	// entry payload and commit port
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (alloc) begin
			ent_dest[tail_idx] <= in_dest;
		end
		// results land out of order
		for (int i = 0; i < LANES; i++) begin
			if (done[i]) begin
				ent_data[done_tag[i]] <= done_data[i];
			end
		end
		if (retire) begin
			commit_dest <= ent_dest[head_idx];
			commit_data <= ent_data[head_idx];
		end
	end

endmodule
